// ==== common/axi_bridge_macros.svh ====
`ifndef AXI_BRIDGE_MACROS_SVH
`define AXI_BRIDGE_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_STRB_W 4

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Transaction IDs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define AXI_ID_W 4

// Instruction fetches.
`define AXI_ID_INST 0
// Loads and stores.
`define AXI_ID_DATA 1

`endif

// ==== common/axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request kinds
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        KIND_INST_RD = 2'd0,
        KIND_DATA_RD = 2'd1,
        KIND_DATA_WR = 2'd2
    } req_kind_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_WAIT = 1'b1
    } arb_state_e;

    typedef enum logic [1:0] {
        WR_IDLE    = 2'd0,
        WR_BUSY    = 2'd1,
        WR_AW_DONE = 2'd2,  // AW accepted, W still pending.
        WR_W_DONE  = 2'd3   // W accepted, AW still pending.
    } write_state_e;

    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_BUSY = 1'b1
    } read_state_e;

endpackage

// ==== hdl/req_arbiter.sv ====
`include "axi_bridge_macros.svh"

module req_arbiter (
    input  logic                          clk,
    input  logic                          resetn,

    input  logic                          inst_req,
    input  logic [`AXI_ADDR_W-1:0]        inst_addr,
    input  logic [1:0]                    inst_size,
    output logic                          inst_addr_ok,

    input  logic                          data_req,
    input  logic                          data_wr,
    input  logic [`AXI_ADDR_W-1:0]        data_addr,
    input  logic [1:0]                    data_size,
    input  logic [`AXI_DATA_W-1:0]        data_wdata,
    input  logic [`AXI_STRB_W-1:0]        data_wstrb,
    output logic                          data_addr_ok,

    input  logic                          done,

    output logic                          rd_start,
    output logic                          wr_start,
    output axi_bridge_pkg::req_kind_e     kind,
    output logic [`AXI_ADDR_W-1:0]        addr,
    output logic [1:0]                    size,
    output logic [`AXI_DATA_W-1:0]        wdata,
    output logic [`AXI_STRB_W-1:0]        wstrb
);
    import axi_bridge_pkg::*;

    arb_state_e state;

    logic inst_acc;
    logic data_acc;

    // Data port has priority.
    assign data_addr_ok = state == ARB_IDLE;
    assign inst_addr_ok = state == ARB_IDLE && !data_req;

    assign data_acc = data_req && data_addr_ok;
    assign inst_acc = inst_req && inst_addr_ok;

    assign rd_start = inst_acc || (data_acc && !data_wr);
    assign wr_start = data_acc && data_wr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ARB_IDLE;
        end else if (state == ARB_IDLE) begin
            if (data_acc || inst_acc) begin
                state <= ARB_WAIT;
            end
        end else if (done) begin
            state <= ARB_IDLE;  // Response seen, ready for the next one.
        end
    end

    // Held until done.
    always_ff @(posedge clk) begin
        if (data_acc) begin
            kind  <= data_wr ? KIND_DATA_WR : KIND_DATA_RD;
            addr  <= data_addr;
            size  <= data_size;
            wdata <= data_wdata;
            wstrb <= data_wstrb;
        end else if (inst_acc) begin
            kind  <= KIND_INST_RD;
            addr  <= inst_addr;
            size  <= inst_size;
        end
    end

endmodule

// ==== write_issuer/write_issuer.sv ====
`include "axi_bridge_macros.svh"

module write_issuer (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   wr_start,
    input  logic [`AXI_ADDR_W-1:0] addr,
    input  logic [1:0]             size,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,

    output logic [`AXI_ID_W-1:0]   awid,
    output logic [`AXI_ADDR_W-1:0] awaddr,
    output logic [7:0]             awlen,
    output logic [2:0]             awsize,
    output logic [1:0]             awburst,
    output logic [1:0]             awlock,
    output logic [3:0]             awcache,
    output logic [2:0]             awprot,
    output logic                   awvalid,
    input  logic                   awready,

    output logic [`AXI_ID_W-1:0]   wid,
    output logic [`AXI_DATA_W-1:0] wdata_o,
    output logic [`AXI_STRB_W-1:0] wstrb_o,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready
);
    import axi_bridge_pkg::*;

    localparam logic [`AXI_ID_W-1:0] ID_DATA = `AXI_ID_DATA;

    write_state_e state;
    write_state_e state_nxt;

    logic aw_fire;
    logic w_fire;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed single-beat attributes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign awid    = ID_DATA;
    assign awlen   = 8'd0;          // One beat.
    assign awburst = 2'b01;         // INCR.
    assign awlock  = 2'b00;
    assign awcache = 4'b0000;
    assign awprot  = 3'b000;
    assign wid     = ID_DATA;
    assign wlast   = 1'b1;

    // Payload is held stable by the arbiter.
    assign awaddr  = addr;
    assign awsize  = {1'b0, size};
    assign wdata_o = wdata;
    assign wstrb_o = wstrb;

    assign awvalid = state == WR_BUSY || state == WR_W_DONE;
    assign wvalid  = state == WR_BUSY || state == WR_AW_DONE;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= WR_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: begin
                if (wr_start) begin
                    state_nxt = WR_BUSY;
                end
            end
            WR_BUSY: begin
                if (aw_fire && w_fire) begin
                    state_nxt = WR_IDLE;
                end else if (aw_fire) begin
                    state_nxt = WR_AW_DONE;
                end else if (w_fire) begin
                    state_nxt = WR_W_DONE;
                end
            end
            WR_AW_DONE: begin
                if (w_fire) begin
                    state_nxt = WR_IDLE;
                end
            end
            WR_W_DONE: begin
                if (aw_fire) begin
                    state_nxt = WR_IDLE;
                end
            end
            default: state_nxt = WR_IDLE;
        endcase
    end

endmodule

// ==== hdl/read_issuer.sv ====
`include "axi_bridge_macros.svh"

module read_issuer (
    input  logic                      clk,
    input  logic                      resetn,

    input  logic                      rd_start,
    input  axi_bridge_pkg::req_kind_e kind,
    input  logic [`AXI_ADDR_W-1:0]    addr,
    input  logic [1:0]                size,

    output logic [`AXI_ID_W-1:0]      arid,
    output logic [`AXI_ADDR_W-1:0]    araddr,
    output logic [7:0]                arlen,
    output logic [2:0]                arsize,
    output logic [1:0]                arburst,
    output logic [1:0]                arlock,
    output logic [3:0]                arcache,
    output logic [2:0]                arprot,
    output logic                      arvalid,
    input  logic                      arready
);
    import axi_bridge_pkg::*;

    localparam logic [`AXI_ID_W-1:0] ID_INST = `AXI_ID_INST;
    localparam logic [`AXI_ID_W-1:0] ID_DATA = `AXI_ID_DATA;

    read_state_e state;

    assign arid    = (kind == KIND_INST_RD) ? ID_INST : ID_DATA;
    assign araddr  = addr;
    assign arsize  = {1'b0, size};
    assign arlen   = 8'd0;
    assign arburst = 2'b01;  // INCR.
    assign arlock  = 2'b00;
    assign arcache = 4'b0000;
    assign arprot  = 3'b000;

    assign arvalid = state == RD_BUSY;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (rd_start) state <= RD_BUSY;
                RD_BUSY: if (arready) state <= RD_IDLE;  // Address taken.
                default: state <= RD_IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/resp_collector.sv ====
`include "axi_bridge_macros.svh"

module resp_collector (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic [`AXI_ID_W-1:0]   rid,
    input  logic [`AXI_DATA_W-1:0] rdata,
    input  logic [1:0]             rresp,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,

    input  logic [`AXI_ID_W-1:0]   bid,
    input  logic [1:0]             bresp,
    input  logic                   bvalid,
    output logic                   bready,

    output logic                   inst_data_ok,
    output logic [`AXI_DATA_W-1:0] inst_rdata,
    output logic                   data_data_ok,
    output logic [`AXI_DATA_W-1:0] data_rdata,

    output logic                   done
);
    localparam logic [`AXI_ID_W-1:0] ID_INST = `AXI_ID_INST;
    localparam logic [`AXI_ID_W-1:0] ID_DATA = `AXI_ID_DATA;

    logic r_fire;
    logic b_fire;
    logic r_inst;

    // Only one transaction is ever in flight.
    assign rready = 1'b1;
    assign bready = 1'b1;

    assign r_fire = rvalid && rready && rlast;
    assign b_fire = bvalid && bready && bid == ID_DATA;
    assign r_inst = rid == ID_INST;

    assign done = r_fire || b_fire;  // Frees the arbiter in the handshake cycle.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            inst_data_ok <= 1'b0;
            data_data_ok <= 1'b0;
        end else begin
            inst_data_ok <= r_fire && r_inst;
            data_data_ok <= (r_fire && !r_inst) || b_fire;
        end
    end

    // Read data registers.
    always_ff @(posedge clk) begin
        if (r_fire && r_inst) begin
            inst_rdata <= rdata;
        end
        if (r_fire && !r_inst) begin
            data_rdata <= rdata;
        end
    end

endmodule

// ==== hdl/cpu_axi_bridge.sv ====
`include "axi_bridge_macros.svh"

module cpu_axi_bridge (
    input  logic                   clk,
    input  logic                   resetn,

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU instruction port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    input  logic                   inst_req,
    input  logic [`AXI_ADDR_W-1:0] inst_addr,
    input  logic [1:0]             inst_size,
    output logic                   inst_addr_ok,
    output logic                   inst_data_ok,
    output logic [`AXI_DATA_W-1:0] inst_rdata,

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CPU data port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    input  logic                   data_req,
    input  logic                   data_wr,
    input  logic [`AXI_ADDR_W-1:0] data_addr,
    input  logic [1:0]             data_size,
    input  logic [`AXI_DATA_W-1:0] data_wdata,
    input  logic [`AXI_STRB_W-1:0] data_wstrb,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,
    output logic [`AXI_DATA_W-1:0] data_rdata,

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // AXI3 master
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    output logic [`AXI_ID_W-1:0]   arid,
    output logic [`AXI_ADDR_W-1:0] araddr,
    output logic [7:0]             arlen,
    output logic [2:0]             arsize,
    output logic [1:0]             arburst,
    output logic [1:0]             arlock,
    output logic [3:0]             arcache,
    output logic [2:0]             arprot,
    output logic                   arvalid,
    input  logic                   arready,

    input  logic [`AXI_ID_W-1:0]   rid,
    input  logic [`AXI_DATA_W-1:0] rdata,
    input  logic [1:0]             rresp,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready,

    output logic [`AXI_ID_W-1:0]   awid,
    output logic [`AXI_ADDR_W-1:0] awaddr,
    output logic [7:0]             awlen,
    output logic [2:0]             awsize,
    output logic [1:0]             awburst,
    output logic [1:0]             awlock,
    output logic [3:0]             awcache,
    output logic [2:0]             awprot,
    output logic                   awvalid,
    input  logic                   awready,

    output logic [`AXI_ID_W-1:0]   wid,
    output logic [`AXI_DATA_W-1:0] wdata,
    output logic [`AXI_STRB_W-1:0] wstrb,
    output logic                   wlast,
    output logic                   wvalid,
    input  logic                   wready,

    input  logic [`AXI_ID_W-1:0]   bid,
    input  logic [1:0]             bresp,
    input  logic                   bvalid,
    output logic                   bready
);
    import axi_bridge_pkg::*;

    logic                   rd_start;
    logic                   wr_start;
    logic                   done;
    req_kind_e              req_kind;
    logic [`AXI_ADDR_W-1:0] req_addr;
    logic [1:0]             req_size;
    logic [`AXI_DATA_W-1:0] req_wdata;
    logic [`AXI_STRB_W-1:0] req_wstrb;

    req_arbiter req_arbiter_i (
        .clk, .resetn,
        .inst_req, .inst_addr, .inst_size, .inst_addr_ok,
        .data_req, .data_wr, .data_addr, .data_size, .data_wdata, .data_wstrb,
        .data_addr_ok, .done, .rd_start, .wr_start,
        .kind (req_kind), .addr (req_addr), .size (req_size),
        .wdata (req_wdata), .wstrb (req_wstrb)
    );

    read_issuer read_issuer_i (
        .clk, .resetn, .rd_start,
        .kind (req_kind), .addr (req_addr), .size (req_size),
        .arid, .araddr, .arlen, .arsize, .arburst, .arlock, .arcache, .arprot,
        .arvalid, .arready
    );

    write_issuer write_issuer_i (
        .clk, .resetn, .wr_start,
        .addr (req_addr), .size (req_size), .wdata (req_wdata), .wstrb (req_wstrb),
        .awid, .awaddr, .awlen, .awsize, .awburst, .awlock, .awcache, .awprot,
        .awvalid, .awready,
        .wid, .wdata_o (wdata), .wstrb_o (wstrb), .wlast, .wvalid, .wready
    );

    resp_collector resp_collector_i (
        .clk, .resetn,
        .rid, .rdata, .rresp, .rlast, .rvalid, .rready,
        .bid, .bresp, .bvalid, .bready,
        .inst_data_ok, .inst_rdata, .data_data_ok, .data_rdata, .done
    );

endmodule

// ==== dv/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    initial begin
        resetn <= 1'b0;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;  // Released on the eighth rising edge.
    end

endmodule

// ==== dv/axi_slave_model.sv ====
`include "axi_bridge_macros.svh"

module axi_slave_model (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`AXI_ID_W-1:0]   arid,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [`AXI_ID_W-1:0]   rid,
    output logic [`AXI_DATA_W-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rlast,
    output logic                   rvalid,
    input  logic                   rready,
    input  logic [`AXI_ID_W-1:0]   awid,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [`AXI_DATA_W-1:0] wdata,
    input  logic [`AXI_STRB_W-1:0] wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [`AXI_ID_W-1:0]   bid,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    output int                     write_count
);
    logic [`AXI_DATA_W-1:0] mem [256];
    logic [1:0]             ar_dly, ar_cnt, aw_dly, aw_cnt, w_dly, w_cnt, r_dly, b_dly;
    logic                   r_pend, b_pend, aw_got, w_got;
    logic [`AXI_ADDR_W-1:0] aw_addr_q;
    logic [`AXI_DATA_W-1:0] w_data_q;
    logic [`AXI_STRB_W-1:0] w_strb_q;
    int                     seed_val;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5ca1_ab1e;
    endfunction

    initial begin
        seed_val = $urandom(32'h9e2b);
    end

    // Ready rises after 0 to 3 cycles of valid.
    assign arready = arvalid && ar_cnt == ar_dly;
    assign awready = awvalid && aw_cnt == aw_dly;
    assign wready  = wvalid && w_cnt == w_dly;
    assign rresp   = 2'b00;
    assign rlast   = 1'b1;
    assign bresp   = 2'b00;

    always @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word({22'd0, 8'(i), 2'b00});
            end
            {ar_dly, ar_cnt, aw_dly, aw_cnt, w_dly, w_cnt, r_dly, b_dly} <= 16'd0;
            {r_pend, b_pend, aw_got, w_got, rvalid, bvalid} <= 6'd0;
            {rid, bid} <= '0;
            rdata <= '0;
            write_count <= 0;
        end else begin
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Read path
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (arvalid && arready) begin
                ar_cnt <= 2'd0;
                ar_dly <= 2'($urandom);
                r_pend <= 1'b1;
                r_dly  <= 2'($urandom);
                rid    <= arid;
                rdata  <= mem[araddr[9:2]];
            end else if (arvalid) begin
                ar_cnt <= ar_cnt + 2'd1;
            end
            if (r_pend && !rvalid) begin
                if (r_dly == 2'd0) begin
                    rvalid <= 1'b1;
                end else begin
                    r_dly <= r_dly - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_pend <= 1'b0;
            end

            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            // Write path
            // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
            if (awvalid && awready) begin
                aw_cnt    <= 2'd0;
                aw_dly    <= 2'($urandom);
                aw_got    <= 1'b1;
                aw_addr_q <= awaddr;
                bid       <= awid;
            end else if (awvalid) begin
                aw_cnt <= aw_cnt + 2'd1;
            end
            if (wvalid && wready) begin
                w_cnt    <= 2'd0;
                w_dly    <= 2'($urandom);
                w_got    <= 1'b1;
                w_data_q <= wdata;
                w_strb_q <= wstrb;
            end else if (wvalid) begin
                w_cnt <= w_cnt + 2'd1;
            end
            if (aw_got && w_got) begin
                for (int b = 0; b < `AXI_STRB_W; b++) begin
                    if (w_strb_q[b]) begin
                        mem[aw_addr_q[9:2]][8*b +: 8] <= w_data_q[8*b +: 8];
                    end
                end
                write_count <= write_count + 1;
                {aw_got, w_got} <= 2'b00;
                b_pend <= 1'b1;
                b_dly  <= 2'($urandom);
            end
            if (b_pend && !bvalid) begin
                if (b_dly == 2'd0) begin
                    bvalid <= 1'b1;
                end else begin
                    b_dly <= b_dly - 2'd1;
                end
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== dv/tb_cpu_axi_bridge.sv ====
`include "axi_bridge_macros.svh"

module tb_cpu_axi_bridge;

    localparam int NUM_ENTRIES = 12;

    // Length 0, INCR burst, no lock, cache or protection bits.
    localparam logic [18:0] SINGLE_BEAT_ATTR = {8'd0, 2'b01, 2'b00, 4'd0, 3'd0};

    typedef struct packed {
        logic                   port;      // High selects the data port.
        logic                   wr;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [1:0]             size;
        logic [`AXI_STRB_W-1:0] wstrb;
        logic [`AXI_DATA_W-1:0] wdata;
        logic                   both_req;  // Instruction request in the same cycle.
    } entry_t;

    logic                   clk, resetn;
    logic                   inst_req, inst_addr_ok, inst_data_ok;
    logic                   data_req, data_wr, data_addr_ok, data_data_ok;
    logic [`AXI_ADDR_W-1:0] inst_addr, data_addr, araddr, awaddr;
    logic [`AXI_DATA_W-1:0] inst_rdata, data_rdata, data_wdata, rdata, wdata;
    logic [`AXI_STRB_W-1:0] data_wstrb, wstrb;
    logic [`AXI_ID_W-1:0]   arid, rid, awid, wid, bid;
    logic [1:0]             inst_size, data_size, rresp, bresp;
    logic [1:0]             arburst, arlock, awburst, awlock;
    logic [7:0]             arlen, awlen;
    logic [2:0]             arsize, arprot, awsize, awprot;
    logic [3:0]             arcache, awcache;
    logic                   arvalid, arready, rlast, rvalid, rready;
    logic                   awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    int                     write_count;

    entry_t                 stim [NUM_ENTRIES];
    logic [`AXI_DATA_W-1:0] ref_mem [256];
    logic                   resp_fire_q;
    logic                   busy;

    clk_gen clk_gen_i (.clk, .resetn);
    cpu_axi_bridge cpu_axi_bridge_i (.*);
    axi_slave_model axi_slave_model_i (.*);

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5ca1_ab1e;
    endfunction

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Takes one request from acceptance to data_ok. Starts on a falling edge.
    task automatic serve(input entry_t e, input logic on_data);
        int   cycles;
        int   count_before;
        logic is_wr;
        is_wr        = on_data && e.wr;
        count_before = write_count;
        while (!(on_data ? data_addr_ok : inst_addr_ok)) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (on_data) begin
            data_req <= 1'b0;
        end else begin
            inst_req <= 1'b0;
        end
        cycles = 0;
        do begin
            @(negedge clk);
            if (cycles == 0) begin
                expect_equal("valid after acceptance",
                             32'(is_wr ? (awvalid && wvalid) : arvalid), 32'd1);
            end
            if (arvalid && arready) begin
                expect_equal("arid", 32'(arid), on_data ? `AXI_ID_DATA : `AXI_ID_INST);
                expect_equal("araddr", araddr, e.addr);
                expect_equal("arsize", 32'(arsize), 32'(e.size));
                expect_equal("AR burst attributes",
                             32'({arlen, arburst, arlock, arcache, arprot}),
                             32'(SINGLE_BEAT_ATTR));
            end
            if (awvalid && awready) begin
                expect_equal("awid", 32'(awid), `AXI_ID_DATA);
                expect_equal("awaddr", awaddr, e.addr);
                expect_equal("awsize", 32'(awsize), 32'(e.size));
                expect_equal("AW burst attributes",
                             32'({awlen, awburst, awlock, awcache, awprot}),
                             32'(SINGLE_BEAT_ATTR));
            end
            if (wvalid && wready) begin
                expect_equal("wid", 32'(wid), `AXI_ID_DATA);
                expect_equal("wlast", 32'(wlast), 32'd1);
                expect_equal("wdata", wdata, e.wdata);
                expect_equal("wstrb", 32'(wstrb), 32'(e.wstrb));
            end
            expect_equal("data_ok of the idle port",
                         32'(on_data ? inst_data_ok : data_data_ok), 32'd0);
            cycles++;
        end while (!(on_data ? data_data_ok : inst_data_ok));
        if (is_wr) begin
            for (int b = 0; b < `AXI_STRB_W; b++) begin
                if (e.wstrb[b]) begin
                    ref_mem[e.addr[9:2]][8*b +: 8] = e.wdata[8*b +: 8];
                end
            end
            expect_equal("write count", write_count, count_before + 1);
        end else begin
            expect_equal("rdata", on_data ? data_rdata : inst_rdata, ref_mem[e.addr[9:2]]);
        end
    endtask

    task automatic run_entry(input entry_t e);
        @(posedge clk);
        if (e.port) begin
            data_req   <= 1'b1;
            data_wr    <= e.wr;
            data_addr  <= e.addr;
            data_size  <= e.size;
            data_wdata <= e.wdata;
            data_wstrb <= e.wstrb;
        end
        if (!e.port || e.both_req) begin
            inst_req  <= 1'b1;
            inst_addr <= e.addr;
            inst_size <= e.size;
        end
        @(negedge clk);
        if (e.port) begin
            expect_equal("inst_addr_ok with data_req high", 32'(inst_addr_ok), 32'd0);
            serve(e, 1'b1);
        end
        if (!e.port || e.both_req) begin
            serve(e, 1'b0);  // Waits behind the data request.
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response timing and ordering monitor
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!resetn) begin
            resp_fire_q = 1'b0;
            busy        = 1'b0;
        end else begin
            expect_equal("data_ok one cycle after R or B",
                         32'(inst_data_ok || data_data_ok), 32'(resp_fire_q));
            if ((inst_req && inst_addr_ok) || (data_req && data_addr_ok)) begin
                expect_equal("request accepted while busy",
                             32'(busy && !(inst_data_ok || data_data_ok)), 32'd0);
                busy = 1'b1;
            end else if (inst_data_ok || data_data_ok) begin
                busy = 1'b0;
            end
            resp_fire_q = (rvalid && rready) || (bvalid && bready);
        end
    end

    initial begin
        repeat (NUM_ENTRIES * 20 + 8) @(posedge clk);
        $display("Timeout: the transactions did not all complete in time");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        {inst_req, data_req, data_wr} <= 3'b000;
        {inst_addr, data_addr, data_wdata} <= '0;
        {inst_size, data_size, data_wstrb} <= '0;
        stim[0]  = '{1'b1, 1'b1, 32'h010, 2'd2, 4'hf, 32'h1122_3344, 1'b0};
        stim[1]  = '{1'b1, 1'b0, 32'h010, 2'd2, 4'h0, 32'h0, 1'b0};
        stim[2]  = '{1'b1, 1'b1, 32'h012, 2'd0, 4'b0100, 32'h00ab_0000, 1'b0};
        stim[3]  = '{1'b1, 1'b0, 32'h010, 2'd2, 4'h0, 32'h0, 1'b0};
        stim[4]  = '{1'b0, 1'b0, 32'h010, 2'd2, 4'h0, 32'h0, 1'b0};
        stim[5]  = '{1'b0, 1'b0, 32'h104, 2'd2, 4'h0, 32'h0, 1'b0};
        stim[6]  = '{1'b1, 1'b1, 32'h022, 2'd1, 4'b1100, 32'hbeef_0000, 1'b1};
        stim[7]  = '{1'b1, 1'b0, 32'h020, 2'd2, 4'h0, 32'h0, 1'b1};
        stim[8]  = '{1'b1, 1'b0, 32'h3fc, 2'd2, 4'h0, 32'h0, 1'b0};
        stim[9]  = '{1'b1, 1'b1, 32'h3fc, 2'd0, 4'b0001, 32'h0000_005a, 1'b0};
        stim[10] = '{1'b0, 1'b0, 32'h3fc, 2'd2, 4'h0, 32'h0, 1'b0};
        stim[11] = '{1'b1, 1'b1, 32'h100, 2'd2, 4'b1010, 32'hdead_beef, 1'b1};
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word({22'd0, 8'(i), 2'b00});
        end
        while (resetn !== 1'b1) @(negedge clk);
        expect_equal("valids and data_ok after reset",
                     32'({arvalid, awvalid, wvalid, inst_data_ok, data_data_ok}), 32'd0);
        expect_equal("addr_ok and ready after reset",
                     32'({inst_addr_ok, data_addr_ok, rready, bready}), 32'hf);
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(stim[i]);
        end
        repeat (2) @(negedge clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/axi_bridge_pkg.sv
hdl/req_arbiter.sv
write_issuer/write_issuer.sv
hdl/read_issuer.sv
hdl/resp_collector.sv
hdl/cpu_axi_bridge.sv
dv/clk_gen.sv
dv/axi_slave_model.sv
dv/tb_cpu_axi_bridge.sv

// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing -sv
SIM_FLAGS  ?= --binary --timing -sv
TOP        ?= tb_cpu_axi_bridge
RTL_TOP    ?= cpu_axi_bridge
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP)

clean:
	rm -rf $(BUILD_DIR)
